// File: bench/tb_pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_ctrl;
  import pipe_pkg::*;

  localparam int N_WR   = 6;
  localparam int N_MISS = N_WR + 8; // three read pairs and two lone reads follow the writes
  localparam int MARGIN = 40;

  typedef struct packed {
    logic             br;
    logic             jmp;
    logic             ld;
    logic             lng;
    logic             den;
    logic [REG_W-1:0] dst;
    logic [REG_W-1:0] s1;
    logic [REG_W-1:0] s2;
    logic             fin;
    logic             pt;
    logic             rt;
    logic [1:0]       e_s1;
    logic [1:0]       e_s2;
    logic             e_fd;
    logic             e_de;
    logic             e_fl;
    logic             e_pn;
  } row_t;

  logic              clk = 1'b0;
  logic              rstn;
  logic              is_branch_i, is_jump_i, is_load_i, is_long_i, dst_en_i;
  logic [REG_W-1:0]  r_dst_i, r_src1_i, r_src2_i;
  logic              fin_i, pred_taken_i, real_taken_i;
  logic              fetch_miss_i, data_miss_i, data_we_i;
  logic [ADDR_W-1:0] fetch_addr_i, data_addr_i;
  logic [DATA_W-1:0] data_wdata_i;
  logic [1:0]        src1_sel_o, src2_sel_o;
  logic              fd_stall_o, de_stall_o, em_stall_o, flush_o, rs1_fwd_o, pt_nt_o;
  logic              fetch_arrival_o, data_arrival_o;
  logic [DATA_W-1:0] fetch_rdata_o, data_rdata_o;

  row_t              rows[$];
  logic [DATA_W-1:0] sb [MEM_WORDS]; // reference copy of the refill memory
  logic [ADDR_W-1:0] wr_addr[$];
  logic              last_port; // 0 is fetch, 1 is data
  int                errors = 0;
  int                cycles = 0;
  int                limit = 0;

  pipe_ctrl_top pipe_ctrl_top_inst (
    .clk(clk), .rstn(rstn),
    .is_branch_i(is_branch_i), .is_jump_i(is_jump_i), .is_load_i(is_load_i),
    .is_long_i(is_long_i), .dst_en_i(dst_en_i),
    .r_dst_i(r_dst_i), .r_src1_i(r_src1_i), .r_src2_i(r_src2_i),
    .fin_i(fin_i), .pred_taken_i(pred_taken_i), .real_taken_i(real_taken_i),
    .fetch_miss_i(fetch_miss_i), .data_miss_i(data_miss_i),
    .fetch_addr_i(fetch_addr_i), .data_addr_i(data_addr_i),
    .data_we_i(data_we_i), .data_wdata_i(data_wdata_i),
    .src1_sel_o(src1_sel_o), .src2_sel_o(src2_sel_o),
    .fd_stall_o(fd_stall_o), .de_stall_o(de_stall_o), .em_stall_o(em_stall_o),
    .flush_o(flush_o), .rs1_fwd_o(rs1_fwd_o), .pt_nt_o(pt_nt_o),
    .fetch_arrival_o(fetch_arrival_o), .data_arrival_o(data_arrival_o),
    .fetch_rdata_o(fetch_rdata_o), .data_rdata_o(data_rdata_o)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit)
    begin
      $display("timeout, the run did not finish within %0d cycles", limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
    if (exp_v !== act_v)
    begin
      errors++;
      $display("Error %s: expected %0h, actual %0h", name, exp_v, act_v);
    end
  endtask

  task automatic add_row(input int br, input int jmp, input int ld, input int lng, input int den,
                         input int dst, input int s1, input int s2, input int fin, input int pt,
                         input int rt, input int es1, input int es2, input int efd,
                         input int ede, input int efl, input int epn);
    row_t r;
    r.br   = br[0];
    r.jmp  = jmp[0];
    r.ld   = ld[0];
    r.lng  = lng[0];
    r.den  = den[0];
    r.dst  = dst[REG_W-1:0];
    r.s1   = s1[REG_W-1:0];
    r.s2   = s2[REG_W-1:0];
    r.fin  = fin[0];
    r.pt   = pt[0];
    r.rt   = rt[0];
    r.e_s1 = es1[1:0];
    r.e_s2 = es2[1:0];
    r.e_fd = efd[0];
    r.e_de = ede[0];
    r.e_fl = efl[0];
    r.e_pn = epn[0];
    rows.push_back(r);
  endtask

  // columns: br jmp ld long dst_en dst src1 src2 fin pred real, then sel1 sel2 fd de flush pt_nt
  task automatic build_table();
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 1,  1,  0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 1,  2,  1, 0, 0, 0, 0,  1, 0, 0, 0, 0, 0); // one back
    add_row(0, 0, 0, 0, 0,  0,  1, 2, 0, 0, 0,  2, 1, 0, 0, 0, 0); // two back on src1
    add_row(0, 0, 0, 0, 1,  0,  2, 0, 0, 0, 0,  2, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 1,  3,  0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0); // r0 written one back
    add_row(0, 0, 0, 0, 1,  3,  0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 0,  0,  3, 3, 0, 0, 0,  1, 1, 0, 0, 0, 0); // same dst twice, newest wins
    add_row(0, 0, 0, 0, 0,  0,  0, 3, 0, 0, 0,  0, 2, 0, 0, 0, 0);
    // load-use
    add_row(0, 0, 1, 0, 1,  4,  0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 1,  5,  4, 0, 0, 0, 0,  1, 0, 1, 1, 0, 0);
    add_row(0, 0, 1, 0, 1,  6,  0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 0,  0,  7, 5, 0, 0, 0,  0, 2, 0, 0, 0, 0);
    // long operation held until fin
    add_row(0, 0, 0, 1, 1,  9,  0, 0, 0, 0, 0,  0, 0, 1, 0, 0, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 1, 0, 0, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 1, 0, 0, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 1, 0, 0,  0, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
    // plain jump
    add_row(0, 1, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 0, 0, 1, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
    // jump whose source is forwarded gets a second flush three cycles on
    add_row(0, 0, 0, 0, 1, 10,  0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
    add_row(0, 1, 0, 0, 0,  0, 10, 0, 0, 0, 0,  1, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 0, 0, 1, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 0, 0, 1, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
    // predicted taken and taken
    add_row(1, 0, 0, 0, 0,  0,  0, 0, 0, 1, 0,  0, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 1,  0, 0, 0, 0, 1, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
    // predicted taken, not taken
    add_row(1, 0, 0, 0, 0,  0,  0, 0, 0, 1, 0,  0, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 0, 0, 1, 1);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 0, 0, 1, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
    // predicted not taken, taken
    add_row(1, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 1,  0, 0, 0, 0, 1, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 0, 0, 1, 0);
    add_row(0, 0, 0, 0, 0,  0,  0, 0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
  endtask

  task automatic issue_miss(input logic do_f, input logic [ADDR_W-1:0] fa, input logic do_d,
                            input logic [ADDR_W-1:0] da, input logic dwe,
                            input logic [DATA_W-1:0] dwd, input string tag);
    logic              f_pend;
    logic              d_pend;
    logic              contend;
    logic              exp_first;
    logic              seen_first;
    logic [DATA_W-1:0] f_exp;
    logic [DATA_W-1:0] d_exp;
    @(posedge clk);
    fetch_miss_i <= do_f;
    fetch_addr_i <= fa;
    data_miss_i  <= do_d;
    data_addr_i  <= da;
    data_we_i    <= dwe;
    data_wdata_i <= dwd;
    f_exp = sb[fa];
    d_exp = dwe ? dwd : sb[da]; // writes return their own word
    if (do_d && dwe)
      sb[da] = dwd;
    contend   = do_f & do_d;
    exp_first = ~last_port; // the port not granted last goes first
    if (contend)
      last_port = ~exp_first;
    else
      last_port = do_d;
    f_pend     = do_f;
    d_pend     = do_d;
    seen_first = 1'b0;
    while (f_pend || d_pend)
    begin
      @(negedge clk);
      check({tag, " fd_stall"}, 32'((f_pend & ~fetch_arrival_o) | (d_pend & ~data_arrival_o)),
            32'(fd_stall_o));
      check({tag, " de_stall"}, 32'(d_pend & ~data_arrival_o), 32'(de_stall_o));
      check({tag, " em_stall"}, 32'(d_pend & ~data_arrival_o), 32'(em_stall_o));
      if (contend && !seen_first && (fetch_arrival_o || data_arrival_o))
      begin
        seen_first = 1'b1;
        if (fetch_arrival_o && data_arrival_o)
        begin
          errors++;
          $display("%s: both refills arrived in the same cycle", tag);
        end
        else
          check({tag, " first port"}, 32'(exp_first), 32'(data_arrival_o));
      end
      if (fetch_arrival_o)
      begin
        if (!f_pend)
        begin
          errors++;
          $display("%s: fetch arrival without an outstanding fetch miss", tag);
        end
        else
          check({tag, " fetch rdata"}, f_exp, fetch_rdata_o);
        f_pend = 1'b0;
      end
      if (data_arrival_o)
      begin
        if (!d_pend)
        begin
          errors++;
          $display("%s: data arrival without an outstanding data miss", tag);
        end
        else
          check({tag, " data rdata"}, d_exp, data_rdata_o);
        d_pend = 1'b0;
      end
      @(posedge clk);
      fetch_miss_i <= 1'b0; // misses are single-cycle pulses
      data_miss_i  <= 1'b0;
    end
  endtask

  initial
  begin
    int          i;
    int          j;
    int          kinds[$];
    row_t        r;
    logic [ADDR_W-1:0] a;
    logic [ADDR_W-1:0] b;
    logic [DATA_W-1:0] w;
    void'($urandom(32'hd1bac6bc));
    rstn         = 1'b0;
    is_branch_i  = 1'b0;
    is_jump_i    = 1'b0;
    is_load_i    = 1'b0;
    is_long_i    = 1'b0;
    dst_en_i     = 1'b0;
    r_dst_i      = '0;
    r_src1_i     = '0;
    r_src2_i     = '0;
    fin_i        = 1'b0;
    pred_taken_i = 1'b0;
    real_taken_i = 1'b0;
    fetch_miss_i = 1'b0;
    data_miss_i  = 1'b0;
    fetch_addr_i = '0;
    data_addr_i  = '0;
    data_we_i    = 1'b0;
    data_wdata_i = '0;
    last_port    = 1'b1;
    build_table();
    limit = rows.size() + 12 * N_MISS + MARGIN;
    repeat (2) @(posedge clk);
    rstn <= 1'b1;

    for (i = 0; i < rows.size(); i++)
    begin
      r = rows[i];
      @(posedge clk);
      is_branch_i  <= r.br;
      is_jump_i    <= r.jmp;
      is_load_i    <= r.ld;
      is_long_i    <= r.lng;
      dst_en_i     <= r.den;
      r_dst_i      <= r.dst;
      r_src1_i     <= r.s1;
      r_src2_i     <= r.s2;
      fin_i        <= r.fin;
      pred_taken_i <= r.pt;
      real_taken_i <= r.rt;
      @(negedge clk);
      check($sformatf("row %0d src1_sel", i), 32'(r.e_s1), 32'(src1_sel_o));
      check($sformatf("row %0d src2_sel", i), 32'(r.e_s2), 32'(src2_sel_o));
      check($sformatf("row %0d rs1_fwd", i), 32'(|r.e_s1), 32'(rs1_fwd_o));
      check($sformatf("row %0d fd_stall", i), 32'(r.e_fd), 32'(fd_stall_o));
      check($sformatf("row %0d de_stall", i), 32'(r.e_de), 32'(de_stall_o));
      check($sformatf("row %0d em_stall", i), 32'd0, 32'(em_stall_o));
      check($sformatf("row %0d flush", i), 32'(r.e_fl), 32'(flush_o));
      check($sformatf("row %0d pt_nt", i), 32'(r.e_pn), 32'(pt_nt_o));
    end

    // the table ends on an idle row, so the hazard inputs are already quiet here
    for (i = 0; i < N_WR; i++)
    begin
      a = ADDR_W'($urandom);
      w = $urandom;
      wr_addr.push_back(a);
      issue_miss(1'b0, '0, 1'b1, a, 1'b1, w, $sformatf("write %0d", i));
      repeat ($urandom % 4) @(posedge clk);
    end

    kinds = '{0, 1, 0, 2, 0}; // 0 is a fetch and data pair, 1 a lone fetch, 2 a lone data read
    for (i = 0; i < kinds.size(); i++)
    begin
      j = $urandom % N_WR;
      a = wr_addr[j];
      j = $urandom % N_WR;
      b = wr_addr[j];
      case (kinds[i])
        0: issue_miss(1'b1, a, 1'b1, b, 1'b0, '0, $sformatf("read pair %0d", i));
        1: issue_miss(1'b1, a, 1'b0, b, 1'b0, '0, $sformatf("fetch read %0d", i));
        default: issue_miss(1'b0, a, 1'b1, b, 1'b0, '0, $sformatf("data read %0d", i));
      endcase
      repeat ($urandom % 4) @(posedge clk);
    end

    $display("run complete, %0d table rows, %0d misses, %0d errors", rows.size(), N_MISS, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       is_branch_i,
  input  logic                       is_jump_i,
  input  logic                       is_load_i,
  input  logic                       is_long_i,
  input  logic                       dst_en_i,
  input  logic [pipe_pkg::REG_W-1:0] r_dst_i,
  input  logic [pipe_pkg::REG_W-1:0] r_src1_i,
  input  logic [pipe_pkg::REG_W-1:0] r_src2_i,
  input  logic                       fin_i,
  input  logic                       pred_taken_i,
  input  logic                       real_taken_i,
  input  logic                       fetch_miss_i,
  input  logic                       data_miss_i,
  input  logic                       fetch_arrival_i,
  input  logic                       data_arrival_i,
  output logic [1:0]                 src1_sel_o,
  output logic [1:0]                 src2_sel_o,
  output logic                       fd_stall_o,
  output logic                       de_stall_o,
  output logic                       em_stall_o,
  output logic                       flush_o,
  output logic                       rs1_fwd_o,
  output logic                       pt_nt_o
);
  import pipe_pkg::*;

  logic [REG_W-1:0] dst_1, dst_2;
  logic             ld_1;
  logic             fetch_keep, data_keep, long_keep;
  logic             fetch_st, data_st, long_st, ldhaz_st;
  logic             jd1;
  logic [2:0]       jfw;
  logic             bpt, bptnt;
  logic             bnt, bnt1;
  logic             flush, fwd_any, take_j, take_b;

  // destination history shifts every cycle, a stall does not hold it
  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      dst_1 <= '0;
      dst_2 <= '0;
      ld_1  <= 1'b0;
    end
    else
    begin
      dst_1 <= (dst_en_i && !flush) ? r_dst_i : '0; // squashed slot writes nothing
      dst_2 <= dst_1;
      ld_1  <= is_load_i & ~flush;
    end
  end

  assign src1_sel_o[0] = (r_src1_i != '0) && (dst_1 == r_src1_i);
  assign src1_sel_o[1] = (r_src1_i != '0) && (dst_1 != dst_2) && (dst_2 == r_src1_i);
  assign src2_sel_o[0] = (r_src2_i != '0) && (dst_1 == r_src2_i);
  assign src2_sel_o[1] = (r_src2_i != '0) && (dst_1 != dst_2) && (dst_2 == r_src2_i);

  assign fwd_any   = (|src1_sel_o) | (|src2_sel_o);
  assign rs1_fwd_o = |src1_sel_o;

  // the load result is not ready in time for a direct consumer
  assign ldhaz_st = ld_1 & (src1_sel_o[0] | src2_sel_o[0]);
  assign fetch_st = ~fetch_arrival_i & (fetch_miss_i | fetch_keep);
  assign data_st  = ~data_arrival_i & (data_miss_i | data_keep);
  assign long_st  = ~(fin_i | flush) & (is_long_i | long_keep);

  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      fetch_keep <= 1'b0;
      data_keep  <= 1'b0;
      long_keep  <= 1'b0;
    end
    else
    begin
      if (fin_i)
        long_keep <= 1'b0;
      else if (is_long_i && !flush)
        long_keep <= 1'b1;

      if (fetch_miss_i)
        fetch_keep <= 1'b1;
      else if (fetch_arrival_i)
        fetch_keep <= 1'b0;

      if (data_miss_i)
        data_keep <= 1'b1;
      else if (data_arrival_i)
        data_keep <= 1'b0;
    end
  end

  assign fd_stall_o = long_st | fetch_st | data_st | ldhaz_st;
  assign de_stall_o = ldhaz_st | data_st;
  assign em_stall_o = data_st;

  // a control transfer decoded under a flush is itself squashed
  assign take_j = is_jump_i & ~flush;
  assign take_b = is_branch_i & ~is_jump_i & ~flush;

  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      jd1   <= 1'b0;
      jfw   <= '0;
      bpt   <= 1'b0;
      bptnt <= 1'b0;
      bnt   <= 1'b0;
      bnt1  <= 1'b0;
    end
    else
    begin
      jd1   <= take_j;
      jfw   <= {jfw[1:0], take_j & fwd_any}; // forwarded jump target lands late
      bpt   <= take_b & pred_taken_i;
      bnt   <= take_b & ~pred_taken_i;
      bptnt <= bpt & ~real_taken_i;
      bnt1  <= bnt & real_taken_i;
    end
  end

  assign flush   = jd1 | jfw[2] | bpt | bptnt | (bnt & real_taken_i) | bnt1;
  assign flush_o = flush;
  assign pt_nt_o = bpt & ~real_taken_i;

  // the fetch side raises one miss and then waits for its refill
  a_fetch_miss_once: assert property (@(posedge clk) disable iff (!rstn)
    fetch_keep |-> !fetch_miss_i);

endmodule

`default_nettype wire

// File: logic/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        p0_req_valid_i,
  output logic                        p0_req_ready_o,
  input  logic [pipe_pkg::ADDR_W-1:0] p0_addr_i,
  input  logic                        p0_we_i,
  input  logic [pipe_pkg::DATA_W-1:0] p0_wdata_i,
  output logic                        p0_resp_valid_o,
  output logic [pipe_pkg::DATA_W-1:0] p0_resp_data_o,
  input  logic                        p1_req_valid_i,
  output logic                        p1_req_ready_o,
  input  logic [pipe_pkg::ADDR_W-1:0] p1_addr_i,
  input  logic                        p1_we_i,
  input  logic [pipe_pkg::DATA_W-1:0] p1_wdata_i,
  output logic                        p1_resp_valid_o,
  output logic [pipe_pkg::DATA_W-1:0] p1_resp_data_o,
  output logic                        m_req_valid_o,
  input  logic                        m_req_ready_i,
  output logic [pipe_pkg::ADDR_W-1:0] m_addr_o,
  output logic                        m_we_o,
  output logic [pipe_pkg::DATA_W-1:0] m_wdata_o,
  input  logic                        m_resp_valid_i,
  input  logic [pipe_pkg::DATA_W-1:0] m_resp_data_i
);

  logic busy;
  logic owner; // last granted port, also the one the response belongs to
  logic any_v;
  logic pick;

  assign any_v = p0_req_valid_i | p1_req_valid_i;
  assign pick  = (p0_req_valid_i && p1_req_valid_i) ? ~owner : p1_req_valid_i;

  assign m_req_valid_o = ~busy & any_v;
  assign m_addr_o      = pick ? p1_addr_i : p0_addr_i;
  assign m_we_o        = pick ? p1_we_i : p0_we_i;
  assign m_wdata_o     = pick ? p1_wdata_i : p0_wdata_i;

  assign p0_req_ready_o = ~busy & p0_req_valid_i & ~pick & m_req_ready_i;
  assign p1_req_ready_o = ~busy & p1_req_valid_i & pick & m_req_ready_i;

  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      busy  <= 1'b0;
      owner <= 1'b1; // so port 0 wins the first contention
    end
    else if (m_req_valid_o && m_req_ready_i)
    begin
      busy  <= 1'b1;
      owner <= pick;
    end
    else if (m_resp_valid_i)
      busy <= 1'b0;
  end

  assign p0_resp_valid_o = m_resp_valid_i & busy & ~owner;
  assign p1_resp_valid_o = m_resp_valid_i & busy & owner;
  assign p0_resp_data_o  = m_resp_data_i;
  assign p1_resp_data_o  = m_resp_data_i;

  // the memory only answers a request that was granted and is still outstanding
  a_resp_owned: assert property (@(posedge clk) disable iff (!rstn)
    m_resp_valid_i |-> busy);

endmodule

`default_nettype wire

// File: logic/miss_port.sv
`timescale 1ns/1ps
`default_nettype none

module miss_port #(
  parameter type req_t = logic [pipe_pkg::ADDR_W-1:0]
) (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        miss_i,
  input  req_t                        req_i,
  output logic                        req_valid_o,
  input  logic                        req_ready_i,
  output logic [pipe_pkg::ADDR_W-1:0] req_addr_o,
  output logic                        req_we_o,
  output logic [pipe_pkg::DATA_W-1:0] req_wdata_o,
  input  logic                        resp_valid_i,
  input  logic [pipe_pkg::DATA_W-1:0] resp_data_i,
  output logic                        arrival_o,
  output logic [pipe_pkg::DATA_W-1:0] rdata_o
);
  import pipe_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT
  } state_t;

  state_t                   state;
  req_t                     req_q;
  logic [$bits(req_t)-1:0]  req_bits;
  logic                     arrival_q;
  logic [DATA_W-1:0]        rdata_q;

  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      state     <= ST_IDLE;
      arrival_q <= 1'b0;
    end
    else
    begin
      arrival_q <= 1'b0;
      case (state)
        ST_IDLE:
          if (miss_i)
            state <= ST_REQ;
        ST_REQ:
          if (req_ready_i)
            state <= ST_WAIT; // request taken by the arbiter
        ST_WAIT:
          if (resp_valid_i)
          begin
            state     <= ST_IDLE;
            arrival_q <= 1'b1;
          end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE && miss_i)
      req_q <= req_i;
    if (state == ST_WAIT && resp_valid_i)
      rdata_q <= resp_data_i;
  end

  assign req_bits    = req_q;
  assign req_valid_o = (state == ST_REQ);
  assign arrival_o   = arrival_q;
  assign rdata_o     = rdata_q;

  // payloads wider than an address carry a write flag and a data word below it
  generate
    if ($bits(req_t) > ADDR_W)
    begin : g_write
      assign req_addr_o  = req_bits[$bits(req_t)-1 -: ADDR_W];
      assign req_we_o    = req_bits[DATA_W];
      assign req_wdata_o = req_bits[DATA_W-1:0];
    end
    else
    begin : g_read
      assign req_addr_o  = req_bits[ADDR_W-1:0];
      assign req_we_o    = 1'b0;
      assign req_wdata_o = '0;
    end
  endgenerate

  a_no_miss_busy: assert property (@(posedge clk) disable iff (!rstn)
    (state != ST_IDLE) |-> !miss_i);

endmodule

`default_nettype wire

// File: logic/pipe_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_top (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        is_branch_i,
  input  logic                        is_jump_i,
  input  logic                        is_load_i,
  input  logic                        is_long_i,
  input  logic                        dst_en_i,
  input  logic [pipe_pkg::REG_W-1:0]  r_dst_i,
  input  logic [pipe_pkg::REG_W-1:0]  r_src1_i,
  input  logic [pipe_pkg::REG_W-1:0]  r_src2_i,
  input  logic                        fin_i,
  input  logic                        pred_taken_i,
  input  logic                        real_taken_i,
  input  logic                        fetch_miss_i,
  input  logic                        data_miss_i,
  input  logic [pipe_pkg::ADDR_W-1:0] fetch_addr_i,
  input  logic [pipe_pkg::ADDR_W-1:0] data_addr_i,
  input  logic                        data_we_i,
  input  logic [pipe_pkg::DATA_W-1:0] data_wdata_i,
  output logic [1:0]                  src1_sel_o,
  output logic [1:0]                  src2_sel_o,
  output logic                        fd_stall_o,
  output logic                        de_stall_o,
  output logic                        em_stall_o,
  output logic                        flush_o,
  output logic                        rs1_fwd_o,
  output logic                        pt_nt_o,
  output logic                        fetch_arrival_o,
  output logic                        data_arrival_o,
  output logic [pipe_pkg::DATA_W-1:0] fetch_rdata_o,
  output logic [pipe_pkg::DATA_W-1:0] data_rdata_o
);
  import pipe_pkg::*;

  // port 0 of the arbiter is fetch, port 1 is data
  logic              f_valid, f_ready, f_we, f_rvalid;
  logic [ADDR_W-1:0] f_addr;
  logic [DATA_W-1:0] f_wdata, f_rdata;
  logic              d_valid, d_ready, d_we, d_rvalid;
  logic [ADDR_W-1:0] d_addr;
  logic [DATA_W-1:0] d_wdata, d_rdata;
  logic              m_valid, m_ready, m_we, m_rvalid;
  logic [ADDR_W-1:0] m_addr;
  logic [DATA_W-1:0] m_wdata, m_rdata;

  hazard_unit u_hazard (
    .clk(clk), .rstn(rstn),
    .is_branch_i(is_branch_i), .is_jump_i(is_jump_i), .is_load_i(is_load_i),
    .is_long_i(is_long_i), .dst_en_i(dst_en_i),
    .r_dst_i(r_dst_i), .r_src1_i(r_src1_i), .r_src2_i(r_src2_i),
    .fin_i(fin_i), .pred_taken_i(pred_taken_i), .real_taken_i(real_taken_i),
    .fetch_miss_i(fetch_miss_i), .data_miss_i(data_miss_i),
    .fetch_arrival_i(fetch_arrival_o), .data_arrival_i(data_arrival_o),
    .src1_sel_o(src1_sel_o), .src2_sel_o(src2_sel_o),
    .fd_stall_o(fd_stall_o), .de_stall_o(de_stall_o), .em_stall_o(em_stall_o),
    .flush_o(flush_o), .rs1_fwd_o(rs1_fwd_o), .pt_nt_o(pt_nt_o)
  );

  miss_port #(.req_t(fetch_req_t)) u_fetch_port (
    .clk(clk), .rstn(rstn),
    .miss_i(fetch_miss_i),
    .req_i(fetch_req_t'{addr: fetch_addr_i}),
    .req_valid_o(f_valid), .req_ready_i(f_ready),
    .req_addr_o(f_addr), .req_we_o(f_we), .req_wdata_o(f_wdata),
    .resp_valid_i(f_rvalid), .resp_data_i(f_rdata),
    .arrival_o(fetch_arrival_o), .rdata_o(fetch_rdata_o)
  );

  miss_port #(.req_t(data_req_t)) u_data_port (
    .clk(clk), .rstn(rstn),
    .miss_i(data_miss_i),
    .req_i(data_req_t'{addr: data_addr_i, we: data_we_i, wdata: data_wdata_i}),
    .req_valid_o(d_valid), .req_ready_i(d_ready),
    .req_addr_o(d_addr), .req_we_o(d_we), .req_wdata_o(d_wdata),
    .resp_valid_i(d_rvalid), .resp_data_i(d_rdata),
    .arrival_o(data_arrival_o), .rdata_o(data_rdata_o)
  );

  mem_arbiter u_arbiter (
    .clk(clk), .rstn(rstn),
    .p0_req_valid_i(f_valid), .p0_req_ready_o(f_ready),
    .p0_addr_i(f_addr), .p0_we_i(f_we), .p0_wdata_i(f_wdata),
    .p0_resp_valid_o(f_rvalid), .p0_resp_data_o(f_rdata),
    .p1_req_valid_i(d_valid), .p1_req_ready_o(d_ready),
    .p1_addr_i(d_addr), .p1_we_i(d_we), .p1_wdata_i(d_wdata),
    .p1_resp_valid_o(d_rvalid), .p1_resp_data_o(d_rdata),
    .m_req_valid_o(m_valid), .m_req_ready_i(m_ready),
    .m_addr_o(m_addr), .m_we_o(m_we), .m_wdata_o(m_wdata),
    .m_resp_valid_i(m_rvalid), .m_resp_data_i(m_rdata)
  );

  refill_mem u_mem (
    .clk(clk), .rstn(rstn),
    .req_valid_i(m_valid), .req_ready_o(m_ready),
    .addr_i(m_addr), .we_i(m_we), .wdata_i(m_wdata),
    .resp_valid_o(m_rvalid), .resp_data_o(m_rdata)
  );

endmodule

`default_nettype wire

// File: logic/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  localparam int REG_W     = 5;
  localparam int ADDR_W    = 8;
  localparam int DATA_W    = 32;
  localparam int MEM_WORDS = 256;
  localparam int MEM_LAT   = 3;
  localparam int LAT_W     = $clog2(MEM_LAT + 1);

  // instruction side only ever reads
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } fetch_req_t;

  // field order matters, the miss port unpacks by position with addr on top
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] wdata;
  } data_req_t;

endpackage

`default_nettype wire

// File: logic/refill_mem.sv
`timescale 1ns/1ps
`default_nettype none

module refill_mem (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  logic [pipe_pkg::ADDR_W-1:0] addr_i,
  input  logic                        we_i,
  input  logic [pipe_pkg::DATA_W-1:0] wdata_i,
  output logic                        resp_valid_o,
  output logic [pipe_pkg::DATA_W-1:0] resp_data_o
);
  import pipe_pkg::*;

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic              busy;
  logic [LAT_W-1:0]  cnt;
  logic [DATA_W-1:0] rd_q;
  logic              accept;

  assign accept       = req_valid_i & ~busy;
  assign req_ready_o  = ~busy;
  assign resp_valid_o = busy & (cnt == '0);
  assign resp_data_o  = rd_q;

  // counts down to the answer cycle, MEM_LAT cycles after acceptance
  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      busy <= 1'b0;
      cnt  <= '0;
    end
    else if (accept)
    begin
      busy <= 1'b1;
      cnt  <= LAT_W'(MEM_LAT - 1);
    end
    else if (busy)
    begin
      if (cnt == '0)
        busy <= 1'b0;
      else
        cnt <= cnt - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      if (we_i)
      begin
        mem[addr_i] <= wdata_i;
        rd_q        <= wdata_i; // a write echoes its own word
      end
      else
        rd_q <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build with Verilator, run, and decide the result from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_pipe_ctrl -f tb.f -o tb_pipe_ctrl > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_pipe_ctrl > sim.log 2>&1 || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0

// File: tb.f
logic/pipe_pkg.sv
logic/hazard_unit.sv
logic/miss_port.sv
logic/mem_arbiter.sv
logic/refill_mem.sv
logic/pipe_ctrl_top.sv
bench/tb_pipe_ctrl.sv
